//--- Makefile
# Verilator build and run for the delay line testbench

VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = var_delay_tb
FILELIST  = tb.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation PASSED
RUN_FLAGS = +verilator+error+limit+1000

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Run passed, see $(LOG)"; \
	else \
		echo "Run failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- source/delay_ctrl.sv
`timescale 1ns/1ps
// **************************************************
// A strobe in the cycle depth changes is dropped
// Depth 0 is a one-cycle bypass, depths past MAX_DEPTH clamp
// **************************************************

module delay_ctrl (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic [delay_pkg::DEPTH_W-1:0] depth,
  input  logic [delay_pkg::DATA_W-1:0]  data_in,
  input  logic                          data_in_valid,
  output logic [delay_pkg::DATA_W-1:0]  data_out,
  output logic                          data_out_valid,
  delay_ram_if.ctrl                     ram
);

  // **************************************************
  // Internal state
  // **************************************************

  // Depth seen on the previous cycle
  logic [delay_pkg::DEPTH_W-1:0] depth_q;

  // Line is flushed this cycle
  logic                          restart;

  // Clamped depth and mode
  logic [delay_pkg::ADDR_W-1:0]  d_eff;
  logic                          bypass;

  // Strobe that is taken into the line
  logic                          accept;

  // Next write slot, wraps over the whole RAM
  logic [delay_pkg::ADDR_W-1:0]  wr_ptr;

  // Accepted words since restart, saturates at d_eff
  logic [delay_pkg::ADDR_W-1:0]  fill_cnt;
  logic                          filled;

  // Output side registers
  logic                          out_valid_q;
  logic                          bypass_q;
  logic [delay_pkg::DATA_W-1:0]  bypass_data;

  // **************************************************
  // Depth handling
  // **************************************************

  // Keep last depth for change detection
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      depth_q <= '0;
    end else begin
      depth_q <= depth;
    end
  end

  // Any change of the level restarts the line
  assign restart = (depth != depth_q);

  // Clamp to what the RAM can hold
  always_comb begin
    if (depth > delay_pkg::DEPTH_W'(delay_pkg::MAX_DEPTH)) begin
      d_eff = delay_pkg::MAX_DEPTH;
    end else begin
      d_eff = depth[delay_pkg::ADDR_W-1:0];
    end
  end

  // Zero depth skips the RAM
  assign bypass = (d_eff == '0);

  // **************************************************
  // Pointers and fill level
  // **************************************************

  assign accept = data_in_valid & ~restart;

  // Line holds d_eff words once full
  // fill_cnt never passes d_eff between restarts
  assign filled = (fill_cnt == d_eff);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr   <= '0;
      fill_cnt <= '0;
    end else if (restart) begin
      wr_ptr   <= '0;
      fill_cnt <= '0;
    end else if (accept) begin
      // Pointer wraps naturally at RAM_WORDS
      wr_ptr <= wr_ptr + 1'b1;
      if (!filled) begin
        fill_cnt <= fill_cnt + 1'b1;
      end
    end
  end

  // **************************************************
  // RAM access
  // **************************************************

  // Every accepted word is stored, also while still filling
  assign ram.wr_en   = accept;
  assign ram.wr_addr = wr_ptr;
  assign ram.wr_data = data_in;

  // Word from d_eff strobes back
  // Modulo subtraction handles the wrap
  assign ram.rd_addr = wr_ptr - d_eff;

  // Read only when its word will be shown
  assign ram.rd_en   = accept & filled & ~bypass;

  // **************************************************
  // Output stage
  // **************************************************

  // Valid trails the strobe by one cycle
  // Restart clears it since accept is low then
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid_q <= 1'b0;
      bypass_q    <= 1'b0;
    end else begin
      out_valid_q <= accept & filled;
      bypass_q    <= bypass;
    end
  end

  // Bypass copy of the input word, payload only
  always_ff @(posedge clk) begin
    if (accept) begin
      bypass_data <= data_in;
    end
  end

  // Mode is taken from the strobe cycle
  // so it lines up with the RAM read latency
  assign data_out       = bypass_q ? bypass_data : ram.rd_data;
  assign data_out_valid = out_valid_q;

endmodule

//--- source/delay_pkg.sv
// **************************************************
// MAX_DEPTH stays one below RAM_WORDS so that a valid read never
// lands on the word being written in the same cycle
// **************************************************

package delay_pkg;

  // **************************************************
  // Sample path
  // **************************************************

  // Width of one sample word
  localparam int DATA_W = 16;

  // **************************************************
  // Delay memory
  // **************************************************

  // Address width of the delay RAM
  localparam int ADDR_W = 8;

  // Number of words in the delay RAM
  localparam int RAM_WORDS = 1 << ADDR_W;

  // **************************************************
  // Depth control
  // **************************************************

  // Width of the run-time depth input
  localparam int DEPTH_W = 16;

  // Largest depth the RAM can hold
  // Anything above is clamped to this value
  localparam logic [ADDR_W-1:0] MAX_DEPTH = ADDR_W'(RAM_WORDS - 1);

endpackage

//--- source/delay_ram.sv
`timescale 1ns/1ps
// **************************************************
// Inferred simple dual-port RAM with no reset
// Contents and read register are undefined after power-up
// **************************************************

module delay_ram (
  input  logic      clk,
  delay_ram_if.ram  ram
);

  // **************************************************
  // Storage
  // **************************************************

  // One word per RAM address
  logic [delay_pkg::DATA_W-1:0] mem [delay_pkg::RAM_WORDS];

  // Read output register
  logic [delay_pkg::DATA_W-1:0] rd_q;

  // **************************************************
  // Write port
  // **************************************************

  // Word lands at the edge where wr_en is high
  always_ff @(posedge clk) begin
    if (ram.wr_en) begin
      mem[ram.wr_addr] <= ram.wr_data;
    end
  end

  // **************************************************
  // Read port
  // **************************************************

  // Registered read, sampled before this edge's write
  // so a colliding address sees the previous contents
  always_ff @(posedge clk) begin
    if (ram.rd_en) begin
      rd_q <= mem[ram.rd_addr];
    end
  end

  // Held between reads
  assign ram.rd_data = rd_q;

endmodule

//--- source/delay_ram_if.sv
`timescale 1ns/1ps
// **************************************************
// Reads return data one edge after rd_en
// Same-address read and write gives the old word
// **************************************************

interface delay_ram_if;

  // **************************************************
  // Write port
  // **************************************************

  // Write strobe, one word per edge
  logic                          wr_en;
  logic [delay_pkg::ADDR_W-1:0]  wr_addr;
  logic [delay_pkg::DATA_W-1:0]  wr_data;

  // **************************************************
  // Read port
  // **************************************************

  // Read request and address
  logic                          rd_en;
  logic [delay_pkg::ADDR_W-1:0]  rd_addr;

  // Registered read word, valid the cycle after rd_en
  logic [delay_pkg::DATA_W-1:0]  rd_data;

  // Controller side drives both addresses
  modport ctrl (
    output wr_en,
    output wr_addr,
    output wr_data,
    output rd_en,
    output rd_addr,
    input  rd_data
  );

  // Memory side
  modport ram (
    input  wr_en,
    input  wr_addr,
    input  wr_data,
    input  rd_en,
    input  rd_addr,
    output rd_data
  );

endinterface

//--- source/var_delay_top.sv
`timescale 1ns/1ps
// **************************************************
// No back-pressure, every accepted word appears at its fixed time
// Change depth only on cycles without a strobe
// **************************************************

module var_delay_top (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic [delay_pkg::DEPTH_W-1:0] depth,
  input  logic [delay_pkg::DATA_W-1:0]  data_in,
  input  logic                          data_in_valid,
  output logic [delay_pkg::DATA_W-1:0]  data_out,
  output logic                          data_out_valid
);

  // **************************************************
  // Controller to RAM link
  // **************************************************

  // Write and read ports of the delay memory
  delay_ram_if ram_bus ();

  // **************************************************
  // Address and output control
  // **************************************************

  delay_ctrl u_ctrl (
    .clk            (clk),
    .arst_n         (arst_n),
    .depth          (depth),
    .data_in        (data_in),
    .data_in_valid  (data_in_valid),
    .data_out       (data_out),
    .data_out_valid (data_out_valid),
    .ram            (ram_bus.ctrl)
  );

  // **************************************************
  // Sample storage
  // **************************************************

  // One cycle read latency, old data on collision
  delay_ram u_ram (
    .clk (clk),
    .ram (ram_bus.ram)
  );

endmodule

//--- tb.f
source/delay_pkg.sv
source/delay_ram_if.sv
source/delay_ram.sv
source/delay_ctrl.sv
source/var_delay_top.sv
test/var_delay_checker.sv
test/var_delay_tb.sv

//--- test/var_delay_checker.sv
`timescale 1ns/1ps
// **************************************************
// Bound into delay_ctrl, expects depth driven from reset on
// **************************************************

module var_delay_checker (
  input logic                          clk,
  input logic                          arst_n,
  input logic [delay_pkg::DEPTH_W-1:0] depth,
  input logic                          data_in_valid,
  input logic                          data_out_valid,
  input logic                          wr_en,
  input logic [delay_pkg::ADDR_W-1:0]  wr_addr,
  input logic [delay_pkg::ADDR_W-1:0]  rd_addr
);

  // **************************************************
  // Failure tally, one counter per property
  // **************************************************

  int unsigned fail_reset   = 0;
  int unsigned fail_follow  = 0;
  int unsigned fail_addr    = 0;
  int unsigned fail_restart = 0;
  int unsigned fail_count;

  assign fail_count = fail_reset + fail_follow + fail_addr + fail_restart;

  // Depth as the RAM sees it
  logic [delay_pkg::ADDR_W-1:0] depth_clamped;
  logic [delay_pkg::ADDR_W-1:0] rd_addr_exp;

  assign depth_clamped = (depth > delay_pkg::DEPTH_W'(delay_pkg::MAX_DEPTH)) ?
                         delay_pkg::MAX_DEPTH : depth[delay_pkg::ADDR_W-1:0];

  // Read trails write by the clamped depth, modulo RAM size
  assign rd_addr_exp = wr_addr - depth_clamped;

  // **************************************************
  // Properties
  // **************************************************

  // No output while reset is held
  reset_valid_low: assert property (@(posedge clk) !arst_n |-> !data_out_valid)
    else begin
      $error("data_out_valid high while in reset");
      fail_reset++;
    end

  // Output only one cycle after a strobe
  valid_follows_strobe: assert property (@(posedge clk) disable iff (!arst_n)
    data_out_valid |-> $past(data_in_valid))
    else begin
      $error("data_out_valid without a strobe in the cycle before");
      fail_follow++;
    end

  read_addr_offset: assert property (@(posedge clk) disable iff (!arst_n)
    rd_addr == rd_addr_exp)
    else begin
      $error("rd_addr is not wr_addr minus clamped depth");
      fail_addr++;
    end

  // Depth change flushes the line, nothing stored that cycle
  no_write_on_restart: assert property (@(posedge clk) disable iff (!arst_n)
    (depth != $past(depth)) |-> !wr_en)
    else begin
      $error("RAM write in a depth change cycle");
      fail_restart++;
    end

endmodule

bind delay_ctrl var_delay_checker u_var_delay_checker (
  .clk            (clk),
  .arst_n         (arst_n),
  .depth          (depth),
  .data_in_valid  (data_in_valid),
  .data_out_valid (data_out_valid),
  .wr_en          (ram.wr_en),
  .wr_addr        (ram.wr_addr),
  .rd_addr        (ram.rd_addr)
);

//--- test/var_delay_tb.sv
`timescale 1ns/1ps
// **************************************************
// Depth changes only on strobe-free cycles, outputs sampled on falling edge
// **************************************************

module var_delay_tb;

  // **************************************************
  // Run constants
  // **************************************************

  localparam int          CLK_PERIOD    = 20;
  localparam int          RESET_CYCLES  = 16;
  localparam logic [31:0] SEED          = 32'hee26;
  localparam int          LINE_MAX      = 255;
  localparam int          IDLE_CYCLES   = 8;
  localparam int          BYPASS_CYCLES = 200;
  localparam int          FIXED_CYCLES  = 300;
  localparam int          CHANGE_CYCLES = 150;
  localparam int          CLAMP_CYCLES  = 1000;
  // Depth changes, drains and the closing cycles
  localparam int          EXTRA_CYCLES  = 64;
  localparam int          TOTAL_CYCLES  = RESET_CYCLES + IDLE_CYCLES + BYPASS_CYCLES
                                          + FIXED_CYCLES + 2 * CHANGE_CYCLES
                                          + CLAMP_CYCLES + EXTRA_CYCLES;
  localparam int          WATCHDOG_NS   = TOTAL_CYCLES * 2 * CLK_PERIOD;

  // **************************************************
  // DUT signals
  // **************************************************

  logic                          clk;
  logic                          arst_n;
  logic [delay_pkg::DEPTH_W-1:0] depth;
  logic [delay_pkg::DATA_W-1:0]  data_in;
  logic                          data_in_valid;
  logic [delay_pkg::DATA_W-1:0]  data_out;
  logic                          data_out_valid;

  // Model state, words of the current run and the next expected output
  logic [delay_pkg::DATA_W-1:0]  hist [$];
  logic [delay_pkg::DEPTH_W-1:0] depth_prev;
  logic                          exp_valid;
  logic [delay_pkg::DATA_W-1:0]  exp_data;

  // Tallies
  int check_count   = 0;
  int err_count     = 0;
  int out_count     = 0;
  int test_count    = 0;
  int test_err_base = 0;
  int test_out_base = 0;

  var_delay_top u_var_delay_top (
    .clk            (clk),
    .arst_n         (arst_n),
    .depth          (depth),
    .data_in        (data_in),
    .data_in_valid  (data_in_valid),
    .data_out       (data_out),
    .data_out_valid (data_out_valid)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // **************************************************
  // Checking
  // **************************************************

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    check_count++;
    if (actual !== expected) begin
      err_count++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
    end
  endtask

  // Reference model, one step per cycle
  // Compares this cycle's output, then predicts the next from this cycle's inputs
  always @(negedge clk) begin : model_step
    int d;
    if (!arst_n) begin
      check_equal(32'(data_out_valid), 32'(1'b0), "data_out_valid in reset");
      hist.delete();
      depth_prev = '0;
      exp_valid  = 1'b0;
    end else begin
      check_equal(32'(data_out_valid), 32'(exp_valid), "data_out_valid");
      if (exp_valid) begin
        check_equal(32'(data_out), 32'(exp_data), "data_out");
      end
      if (data_out_valid) begin
        out_count++;
      end
      // Depths past the RAM limit act as the limit
      d = (int'(depth) > LINE_MAX) ? LINE_MAX : int'(depth);
      exp_valid = 1'b0;
      if (depth != depth_prev) begin
        // Restart, the strobe slot is lost
        hist.delete();
      end else if (data_in_valid) begin
        if (d == 0) begin
          exp_valid = 1'b1;
          exp_data  = data_in;
        end else begin
          hist.push_back(data_in);
          // Line is full, oldest word is D strobes back
          if (hist.size() > d) begin
            exp_valid = 1'b1;
            exp_data  = hist.pop_front();
          end
        end
      end
      depth_prev = depth;
    end
  end

  // **************************************************
  // Stimulus
  // **************************************************

  task automatic set_depth(input int new_depth);
    @(posedge clk);
    depth         <= delay_pkg::DEPTH_W'(new_depth);
    data_in_valid <= 1'b0;
    // Strobe stays off one more cycle
    @(posedge clk);
    data_in_valid <= 1'b0;
  endtask

  // Random words, strobe dropped with gap_pct percent chance
  task automatic run_stream(input int cycles, input int gap_pct);
    for (int i = 0; i < cycles; i++) begin
      @(posedge clk);
      data_in_valid <= (($urandom % 100) >= gap_pct);
      data_in       <= delay_pkg::DATA_W'($urandom);
    end
    // Drain the last output
    @(posedge clk);
    data_in_valid <= 1'b0;
    @(posedge clk);
  endtask

  task automatic finish_test(input string name);
    test_count++;
    $display("Test %0d %s done: %0d errors, %0d outputs", test_count, name,
             err_count - test_err_base, out_count - test_out_base);
    test_err_base = err_count;
    test_out_base = out_count;
  endtask

  initial begin : stimulus
    int fixed_d;
    int first_d;
    int second_d;
    void'($urandom(SEED));
    arst_n        = 1'b0;
    depth         = '0;
    data_in       = '0;
    data_in_valid = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    arst_n <= 1'b1;

    // Quiet line after reset
    repeat (IDLE_CYCLES) @(posedge clk);
    finish_test("reset");

    // Depth stays 0 from reset
    run_stream(BYPASS_CYCLES, 30);
    finish_test("bypass");

    fixed_d = 1 + int'($urandom % 40);
    set_depth(fixed_d);
    run_stream(FIXED_CYCLES, 30);
    finish_test($sformatf("fixed depth %0d", fixed_d));

    // Second depth always differs from the first
    first_d  = 1 + int'($urandom % 40);
    second_d = first_d + 1 + int'($urandom % 20);
    set_depth(first_d);
    run_stream(CHANGE_CYCLES, 20);
    set_depth(second_d);
    run_stream(CHANGE_CYCLES, 20);
    finish_test($sformatf("depth change %0d to %0d", first_d, second_d));

    // Several passes through the RAM at the limit
    set_depth(1000);
    run_stream(CLAMP_CYCLES, 0);
    finish_test("clamp and wrap");

    repeat (4) @(posedge clk);
    err_count += int'(u_var_delay_top.u_ctrl.u_var_delay_checker.fail_count);
    $display("Done: %0d tests, %0d checks, %0d errors, %0d assertion failures",
             test_count, check_count, err_count,
             u_var_delay_top.u_ctrl.u_var_delay_checker.fail_count);
    if (err_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // **************************************************
  // Watchdog
  // **************************************************

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("Simulation FAILED");
    $finish;
  end

endmodule
